/* program.hex */
// test program for the instruction memory, one 32-bit word per line in hex
// word n sits at pc 4*n; the comment gives that pc and the assembly
20010005 // 00 addi $1, $0, 5
2002FFFD // 04 addi $2, $0, -3
00221820 // 08 add  $3, $1, $2
00222022 // 0c sub  $4, $1, $2
00642825 // 10 or   $5, $3, $4
00A23024 // 14 and  $6, $5, $2
0041382A // 18 slt  $7, $2, $1
AC050008 // 1c sw   $5, 8($0)
8C080008 // 20 lw   $8, 8($0)
01084820 // 24 add  $9, $8, $8
11050001 // 28 beq  $8, $5, +1  taken
200A0001 // 2c addi $10, $0, 1  skipped
15090001 // 30 bne  $8, $9, +1  taken
200A0002 // 34 addi $10, $0, 2  skipped
11090001 // 38 beq  $8, $9, +1  not taken
15050001 // 3c bne  $8, $5, +1  not taken
200A0003 // 40 addi $10, $0, 3
20000007 // 44 addi $0, $0, 7   write to r0
8C0B0002 // 48 lw   $11, 2($0)  misaligned
FC000000 // 4c undefined opcode
200C8000 // 50 addi $12, $0, -32768
018C6020 // 54 add  $12, $12, $12
018C6020 // 58 add  $12, $12, $12
018C6020 // 5c add  $12, $12, $12
018C6020 // 60 add  $12, $12, $12
018C6020 // 64 add  $12, $12, $12
018C6020 // 68 add  $12, $12, $12
018C6020 // 6c add  $12, $12, $12
018C6020 // 70 add  $12, $12, $12
018C6020 // 74 add  $12, $12, $12
018C6020 // 78 add  $12, $12, $12
018C6020 // 7c add  $12, $12, $12
018C6020 // 80 add  $12, $12, $12
018C6020 // 84 add  $12, $12, $12
018C6020 // 88 add  $12, $12, $12
018C6020 // 8c add  $12, $12, $12
018C6020 // 90 add  $12, $12, $12
01826820 // 94 add  $13, $12, $2  overflow
01AA7020 // 98 add  $14, $13, $10
1000FFFF // 9c beq  $0, $0, -1  spin here

/* filelist.f */
mips_pkg.sv
reg_file.sv
fetch_stage.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_mips_core
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb_mips_core.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_mips_core
// Runs program.hex through the pipelined core and compares every retire
// and exception strobe with a hand-built table of events in order.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_mips_core import mips_pkg::*;
();

    logic    SYS_clk;
    logic    SYS_reset;
    commit_t retire;
    exc_t    exc;

    // expected events, one row per strobe, in program order
    logic    row_is_exc [$];
    commit_t row_commit [$];
    exc_t    row_exc [$];

    int      next_row;
    int      cycles;

    mips_core i_dut
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .retire    (retire),
        .exc       (exc)
    );

    always
    begin
        #50 SYS_clk = ~SYS_clk;                 // 100 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic void retire_row(input logic [XLEN-1:0]   pc,
                                       input logic              reg_write,
                                       input logic [REG_AW-1:0] dest,
                                       input logic [XLEN-1:0]   data);
        commit_t c;
        exc_t    e;
        c           = '0;
        e           = '0;
        c.valid     = 1'b1;
        c.pc        = pc;
        c.reg_write = reg_write;
        c.dest      = dest;
        c.data      = data;
        row_is_exc.push_back(1'b0);
        row_commit.push_back(c);
        row_exc.push_back(e);
    endfunction

    function automatic void fault_row(input exc_cause_t cause, input logic [XLEN-1:0] epc);
        commit_t c;
        exc_t    e;
        c       = '0;
        e       = '0;
        e.valid = 1'b1;
        e.cause = cause;
        e.epc   = epc;
        row_is_exc.push_back(1'b1);
        row_commit.push_back(c);
        row_exc.push_back(e);
    endfunction

    task automatic check_commit(input int row, input commit_t got, input commit_t want);
        logic bad;
        bad = (got.pc !== want.pc) || (got.reg_write !== want.reg_write);
        if (want.reg_write)                     // dest and data only mean something for writers
            bad = bad || (got.dest !== want.dest) || (got.data !== want.data);
        if (bad)
            abort_run({$sformatf("Error at %0t: event %0d retired pc %h rw %b r%0d=%h",
                                 $time, row, got.pc, got.reg_write, got.dest, got.data),
                       $sformatf(", expected pc %h rw %b r%0d=%h",
                                 want.pc, want.reg_write, want.dest, want.data)});
    endtask

    task automatic check_exc(input int row, input exc_t got, input exc_t want);
        if (got.cause !== want.cause || got.epc !== want.epc)
            abort_run({$sformatf("Error at %0t: event %0d cause %0d epc %h",
                                 $time, row, got.cause, got.epc),
                       $sformatf(", expected cause %0d epc %h", want.cause, want.epc)});
    endtask

    task automatic load_events();
        // arithmetic and logic, with one- and two-apart dependencies
        retire_row(32'h00, 1'b1, 5'd1, 32'h0000_0005);
        retire_row(32'h04, 1'b1, 5'd2, 32'hFFFF_FFFD);
        retire_row(32'h08, 1'b1, 5'd3, 32'h0000_0002);
        retire_row(32'h0c, 1'b1, 5'd4, 32'h0000_0008);
        retire_row(32'h10, 1'b1, 5'd5, 32'h0000_000A);
        retire_row(32'h14, 1'b1, 5'd6, 32'h0000_0008);
        retire_row(32'h18, 1'b1, 5'd7, 32'h0000_0001);   // signed compare
        // store, load back, load-use
        retire_row(32'h1c, 1'b0, 5'd0, 32'h0);
        retire_row(32'h20, 1'b1, 5'd8, 32'h0000_000A);
        retire_row(32'h24, 1'b1, 5'd9, 32'h0000_0014);
        // two taken branches skip 0x2c and 0x34, two fall through
        retire_row(32'h28, 1'b0, 5'd0, 32'h0);
        retire_row(32'h30, 1'b0, 5'd0, 32'h0);
        retire_row(32'h38, 1'b0, 5'd0, 32'h0);
        retire_row(32'h3c, 1'b0, 5'd0, 32'h0);
        retire_row(32'h40, 1'b1, 5'd10, 32'h0000_0003);
        // three faults in a row, each resumes at epc + 4
        fault_row(EXC_ZERO_WRITE, 32'h44);
        fault_row(EXC_MISALIGNED, 32'h48);
        fault_row(EXC_UNDEF, 32'h4c);
        // r12 doubles up to the most negative value
        retire_row(32'h50, 1'b1, 5'd12, 32'hFFFF_8000);
        retire_row(32'h54, 1'b1, 5'd12, 32'hFFFF_0000);
        retire_row(32'h58, 1'b1, 5'd12, 32'hFFFE_0000);
        retire_row(32'h5c, 1'b1, 5'd12, 32'hFFFC_0000);
        retire_row(32'h60, 1'b1, 5'd12, 32'hFFF8_0000);
        retire_row(32'h64, 1'b1, 5'd12, 32'hFFF0_0000);
        retire_row(32'h68, 1'b1, 5'd12, 32'hFFE0_0000);
        retire_row(32'h6c, 1'b1, 5'd12, 32'hFFC0_0000);
        retire_row(32'h70, 1'b1, 5'd12, 32'hFF80_0000);
        retire_row(32'h74, 1'b1, 5'd12, 32'hFF00_0000);
        retire_row(32'h78, 1'b1, 5'd12, 32'hFE00_0000);
        retire_row(32'h7c, 1'b1, 5'd12, 32'hFC00_0000);
        retire_row(32'h80, 1'b1, 5'd12, 32'hF800_0000);
        retire_row(32'h84, 1'b1, 5'd12, 32'hF000_0000);
        retire_row(32'h88, 1'b1, 5'd12, 32'hE000_0000);
        retire_row(32'h8c, 1'b1, 5'd12, 32'hC000_0000);
        retire_row(32'h90, 1'b1, 5'd12, 32'h8000_0000);
        fault_row(EXC_OVERFLOW, 32'h94);
        retire_row(32'h98, 1'b1, 5'd14, 32'h0000_0003);   // r13 never written
        retire_row(32'h9c, 1'b0, 5'd0, 32'h0);            // first pass of the spin loop
    endtask

    always @(posedge SYS_clk)
    begin
        if (!SYS_reset)
        begin
            cycles++;
            if (cycles >= 4 * row_is_exc.size() + 20)
                abort_run({"Timeout: ",
                           $sformatf("only %0d of %0d expected events arrived in %0d cycles",
                                     next_row, row_is_exc.size(), cycles)});
        end
    end

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        next_row  = 0;
        cycles    = 0;
        load_events();

        repeat (3) @(posedge SYS_clk);
        #1 SYS_reset = 1'b0;
        if (retire.valid || exc.valid)
            abort_run($sformatf("Error at %0t: strobe raised straight out of reset", $time));

        while (next_row < row_is_exc.size())
        begin
            @(negedge SYS_clk);                 // outputs settled since the rising edge
            if (retire.valid && exc.valid)
                abort_run($sformatf("Error at %0t: retire and exception in the same cycle",
                                    $time));
            else if (retire.valid)
            begin
                if (row_is_exc[next_row])
                    abort_run($sformatf("Error at %0t: retire of pc %h where event %0d is a fault",
                                        $time, retire.pc, next_row));
                else
                begin
                    check_commit(next_row, retire, row_commit[next_row]);
                    next_row++;
                end
            end
            else if (exc.valid)
            begin
                if (!row_is_exc[next_row])
                    abort_run($sformatf("Error at %0t: fault at epc %h where event %0d is a retire",
                                        $time, exc.epc, next_row));
                else
                begin
                    check_exc(next_row, exc, row_exc[next_row]);
                    next_row++;
                end
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* mips_core.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips_core
// Five-stage pipelined MIPS subset; reports each retired instruction
// and each exception as one-cycle strobes.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mips_core import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    output commit_t retire,
    output exc_t    exc
);

    logic [XLEN-1:0] f_pc;
    instr_t          f_instr;
    instr_t          d_instr;
    id_ex_t          id_ex;
    id_ex_t          id_ex_reg;
    ex_mem_t         ex_result;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    logic            stall;
    logic            fwd_rs;
    logic            fwd_rt;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    logic            flush;

    assign flush = exc.valid;                   // kills everything younger

    fetch_stage i_fetch
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exc           (exc),
        .pc            (f_pc),
        .instr         (f_instr)
    );

    decode_stage i_decode
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .f_pc          (f_pc),
        .f_instr       (f_instr),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .flush         (flush),
        .mem_result    (ex_mem.alu_result),
        .wb_commit     (retire),
        .d_instr       (d_instr),
        .id_ex         (id_ex),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    hazard_unit i_hazard
    (
        .d_instr (d_instr),
        .id_ex   (id_ex_reg),
        .ex_mem  (ex_mem),
        .stall   (stall),
        .fwd_rs  (fwd_rs),
        .fwd_rt  (fwd_rt)
    );

    execute_stage i_execute
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (flush),
        .id_ex     (id_ex),
        .id_ex_reg (id_ex_reg),
        .ex_mem    (ex_result)
    );

    memory_stage i_memory
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (flush),
        .exc       (exc),
        .ex_result (ex_result),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb)
    );

    writeback_stage i_writeback
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .mem_wb    (mem_wb),
        .retire    (retire),
        .exc       (exc)
    );

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback_stage
// MEM/WB register and result select. Clean instructions retire; any
// tagged one raises the exception report that flushes the pipeline.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module writeback_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  mem_wb_t mem_wb,
    output commit_t retire,
    output exc_t    exc
);

    mem_wb_t         wb;
    exc_cause_t      cause;
    logic [XLEN-1:0] result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            wb <= '0;
        else
            wb <= mem_wb;
    end

    assign result = wb.ctrl.mem_read ? wb.load_data : wb.alu_result;

    always_comb
    begin
        cause = wb.cause;
        if (cause == EXC_NONE && wb.ctrl.reg_write && wb.dest == '0)
            cause = EXC_ZERO_WRITE;
    end

    assign retire.valid     = wb.valid && (cause == EXC_NONE);
    assign retire.pc        = wb.pc;
    assign retire.reg_write = wb.ctrl.reg_write;
    assign retire.dest      = wb.dest;
    assign retire.data      = result;

    assign exc.valid = wb.valid && (cause != EXC_NONE);
    assign exc.cause = cause;
    assign exc.epc   = wb.pc;                   // fetch resumes at epc + 4

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory_stage
// EX/MEM register and word-addressed data memory. Misaligned accesses
// turn into a bubble; stores are blocked while an exception is raised.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memory_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    flush,
    input  exc_t    exc,
    input  ex_mem_t ex_result,
    output ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);

    logic [XLEN-1:0]               dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] word_addr;
    logic                          fault;
    logic                          mem_wr;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else if (flush)
            ex_mem <= '0;
        else
            ex_mem <= ex_result;
    end

    assign word_addr = ex_mem.alu_result[$clog2(DMEM_WORDS)+1:2];
    assign fault     = (ex_mem.cause != EXC_NONE);
    assign mem_wr    = ex_mem.ctrl.mem_write && !fault && !exc.valid;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (mem_wr)
            dmem[word_addr] <= ex_mem.store_data;
    end

    always_comb
    begin
        mem_wb = '0;
        if (!exc.valid)                         // younger than the fault in writeback
        begin
            mem_wb.valid      = ex_mem.valid;
            mem_wb.pc         = ex_mem.pc;
            mem_wb.ctrl       = fault ? ctrl_t'('0) : ex_mem.ctrl;
            mem_wb.alu_result = ex_mem.alu_result;
            mem_wb.load_data  = (ex_mem.ctrl.mem_read && !fault) ? dmem[word_addr] : '0;
            mem_wb.dest       = ex_mem.dest;
            mem_wb.cause      = ex_mem.cause;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute_stage
// ID/EX register and ALU. Signed overflow kills the instruction;
// misaligned load/store addresses are tagged for the memory stage.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module execute_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    flush,
    input  id_ex_t  id_ex,
    output id_ex_t  id_ex_reg,
    output ex_mem_t ex_mem
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] result;
    logic            mem_access;
    logic            overflow;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex_reg <= '0;
        else if (flush)
            id_ex_reg <= '0;
        else
            id_ex_reg <= id_ex;
    end

    assign op_a = id_ex_reg.rs_val;
    assign op_b = id_ex_reg.ctrl.alu_src_imm ? id_ex_reg.imm : id_ex_reg.rt_val;
    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    always_comb
    begin
        case (id_ex_reg.ctrl.alu_op)
            ALU_SUB: result = diff;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = sum;
        endcase
    end

    // address arithmetic never traps
    assign mem_access = id_ex_reg.ctrl.mem_read || id_ex_reg.ctrl.mem_write;
    always_comb
    begin
        overflow = 1'b0;
        if (id_ex_reg.ctrl.reg_write && !mem_access)
        begin
            if (id_ex_reg.ctrl.alu_op == ALU_ADD)
                overflow = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
            else if (id_ex_reg.ctrl.alu_op == ALU_SUB)
                overflow = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);
        end
    end

    // an earlier fault left ctrl empty, so its cause passes untouched
    always_comb
    begin
        ex_mem.valid      = id_ex_reg.valid;
        ex_mem.pc         = id_ex_reg.pc;
        ex_mem.ctrl       = id_ex_reg.ctrl;
        ex_mem.alu_result = result;
        ex_mem.store_data = id_ex_reg.rt_val;
        ex_mem.dest       = id_ex_reg.dest;
        ex_mem.cause      = id_ex_reg.cause;
        if (overflow)
        begin
            ex_mem.ctrl  = '0;
            ex_mem.cause = EXC_OVERFLOW;
        end
        else if (mem_access && result[1:0] != 2'b00)
            ex_mem.cause = EXC_MISALIGNED;     // memory stage drops the access
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode_stage
// IF/ID register, control decode, operand read with forwarding and
// early branch resolution. Unknown words leave as a tagged bubble.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decode_stage import mips_pkg::*;
(
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic [XLEN-1:0] f_pc,
    input  instr_t          f_instr,
    input  logic            stall,
    input  logic            fwd_rs,
    input  logic            fwd_rt,
    input  logic            flush,
    input  logic [XLEN-1:0] mem_result,
    input  commit_t         wb_commit,
    output instr_t          d_instr,
    output id_ex_t          id_ex,
    output logic            branch_taken,
    output logic [XLEN-1:0] branch_target
);

    logic            d_valid;
    logic [XLEN-1:0] d_pc;
    ctrl_t           ctrl;
    logic            undef;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] rf_rs;
    logic [XLEN-1:0] rf_rt;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic            is_branch;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            d_valid <= 1'b0;
            d_pc    <= '0;
            d_instr <= '0;
        end
        else if (flush || branch_taken)         // wrong path or younger than a fault
        begin
            d_valid <= 1'b0;
            d_pc    <= '0;
            d_instr <= '0;
        end
        else if (!stall)
        begin
            d_valid <= 1'b1;
            d_pc    <= f_pc;
            d_instr <= f_instr;
        end
    end

    always_comb
    begin
        ctrl  = '0;
        undef = 1'b0;
        case (d_instr.r.opcode)
            OP_RTYPE:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.dest_is_rd = 1'b1;
                case (d_instr.r.funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: undef = 1'b1;      // no shifts or multiply
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ, OP_BNE:
                undef = 1'b0;                   // finished here, nothing downstream
            default:
                undef = 1'b1;
        endcase
    end

    assign imm_ext = {{(XLEN-16){d_instr.i.imm[15]}}, d_instr.i.imm};

    reg_file i_reg_file
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (d_instr.r.rs),
        .rt_addr   (d_instr.r.rt),
        .wr        (wb_commit),
        .rs_data   (rf_rs),
        .rt_data   (rf_rt)
    );

    assign rs_val = fwd_rs ? mem_result : rf_rs;
    assign rt_val = fwd_rt ? mem_result : rf_rt;

    // beq wants equal operands, bne wants them different
    assign is_branch     = d_valid && (d_instr.i.opcode == OP_BEQ || d_instr.i.opcode == OP_BNE);
    assign branch_taken  = is_branch && !stall
                           && ((d_instr.i.opcode == OP_BEQ) == (rs_val == rt_val));
    assign branch_target = d_pc + 32'd4 + {imm_ext[XLEN-3:0], 2'b00};

    always_comb
    begin
        id_ex = '0;                             // bubble
        if (d_valid && !stall)
        begin
            id_ex.valid  = 1'b1;
            id_ex.pc     = d_pc;
            id_ex.ctrl   = ctrl;
            id_ex.rs_val = rs_val;
            id_ex.rt_val = rt_val;
            id_ex.imm    = imm_ext;
            id_ex.dest   = ctrl.dest_is_rd ? d_instr.r.rd : d_instr.r.rt;
            if (undef)
            begin
                id_ex.ctrl  = '0;
                id_ex.cause = EXC_UNDEF;
            end
        end
    end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hazard_unit
// Checks decode sources against the execute and memory destinations;
// stalls decode or forwards the memory-stage ALU result.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hazard_unit import mips_pkg::*;
(
    input  instr_t  d_instr,
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    output logic    stall,
    output logic    fwd_rs,
    output logic    fwd_rt
);

    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic              uses_rt;
    logic              ex_writer;
    logic              mem_load;
    logic              mem_alu_writer;

    assign rs = d_instr.r.rs;
    assign rt = d_instr.r.rt;
    assign uses_rt = (d_instr.r.opcode == OP_RTYPE) || (d_instr.r.opcode == OP_BEQ)
                     || (d_instr.r.opcode == OP_BNE) || (d_instr.r.opcode == OP_SW);

    assign ex_writer      = id_ex.ctrl.reg_write && (id_ex.dest != '0);
    assign mem_load       = ex_mem.ctrl.mem_read && (ex_mem.dest != '0);
    assign mem_alu_writer = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read
                            && (ex_mem.dest != '0);

    // result not ready yet in execute; load data not ready until writeback
    assign stall = (ex_writer && (id_ex.dest == rs || (uses_rt && id_ex.dest == rt)))
                   || (mem_load && (ex_mem.dest == rs || (uses_rt && ex_mem.dest == rt)));

    assign fwd_rs = mem_alu_writer && (ex_mem.dest == rs);
    assign fwd_rt = mem_alu_writer && uses_rt && (ex_mem.dest == rt);

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_stage
// Program counter with exception, branch and stall redirect, and the
// instruction memory read in the same cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetch_stage import mips_pkg::*;
(
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic            stall,
    input  logic            branch_taken,
    input  logic [XLEN-1:0] branch_target,
    input  exc_t            exc,
    output logic [XLEN-1:0] pc,
    output instr_t          instr
);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc_next;

    initial
    begin
        $readmemh("program.hex", imem);
    end

    always_comb
    begin
        if (exc.valid)
            pc_next = exc.epc + 32'd4;          // skip the faulting instruction
        else if (branch_taken)
            pc_next = branch_target;
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    assign instr = imem[pc[$clog2(IMEM_WORDS)+1:2]];   // word addressed

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reg_file
// 32 x 32 register file, two read ports and one write-through port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module reg_file import mips_pkg::*;
(
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic [REG_AW-1:0] rs_addr,
    input  logic [REG_AW-1:0] rt_addr,
    input  commit_t           wr,
    output logic [XLEN-1:0]   rs_data,
    output logic [XLEN-1:0]   rt_data
);

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_en;

    assign wr_en = wr.valid && wr.reg_write && (wr.dest != '0);   // r0 stays zero

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr.dest] <= wr.data;
    end

    // decode sees the value retiring in the same cycle
    assign rs_data = (wr_en && wr.dest == rs_addr) ? wr.data : regs[rs_addr];
    assign rt_data = (wr_en && wr.dest == rt_addr) ? wr.data : regs[rt_addr];

endmodule

/* mips_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips_pkg
// Widths, opcodes, instruction formats and the structs passed between
// the five stages of the pipelined MIPS core.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

    typedef enum logic [2:0] {
        EXC_NONE, EXC_UNDEF, EXC_OVERFLOW, EXC_MISALIGNED, EXC_ZERO_WRITE
    } exc_cause_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_form_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_form_t;

    // same word seen as register form or immediate form
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    dest_is_rd;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        ctrl_t             ctrl;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] dest;
        exc_cause_t        cause;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        ctrl_t             ctrl;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] dest;
        exc_cause_t        cause;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        ctrl_t             ctrl;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   load_data;
        logic [REG_AW-1:0] dest;
        exc_cause_t        cause;
    } mem_wb_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic              reg_write;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   data;
    } commit_t;

    typedef struct packed {
        logic            valid;
        exc_cause_t      cause;
        logic [XLEN-1:0] epc;
    } exc_t;

endpackage
